// ==== lc4_defs.svh ====
`ifndef LC4_DEFS_SVH
`define LC4_DEFS_SVH

// machine word width in bits
`define LC4_WORD_W 16

// general purpose registers r0..r7
`define LC4_REG_CNT 8

// address of the first fetch after reset
`define LC4_RESET_PC 16'h8200

// upper bound in cycles on any single wait in simulation
`define LC4_HALT_CYCLES 20000

`endif

// ==== lc4_isa_pkg.sv ====
`include "lc4_defs.svh"

package lc4_isa_pkg;

   typedef logic [`LC4_WORD_W-1:0] lc4_word_t;
   typedef logic [$clog2(`LC4_REG_CNT)-1:0] lc4_reg_t;

   // only the opcodes this core executes, any other value decodes to a bubble
   typedef enum logic [3:0] {
      op_br    = 4'b0000,
      op_arith = 4'b0001,
      op_logic = 4'b0101,
      op_ldr   = 4'b0110,
      op_str   = 4'b0111,
      op_const = 4'b1001
   } lc4_opcode_t;

   typedef struct packed {
      logic n;
      logic z;
      logic p;
   } lc4_nzp_t;

   // register ops, sub[2] set means ADD-immediate with imm5 in the low bits
   typedef struct packed {
      lc4_opcode_t opcode;
      lc4_reg_t    rd;
      lc4_reg_t    rs;
      logic [2:0]  sub;
      lc4_reg_t    rt;
   } lc4_rform_t;

   // LDR rd or STR rt, base register rs
   typedef struct packed {
      lc4_opcode_t opcode;
      lc4_reg_t    rd;
      lc4_reg_t    rs;
      logic [5:0]  imm;
   } lc4_oform_t;

   // CONST rd or BR nzp mask
   typedef struct packed {
      lc4_opcode_t opcode;
      logic [2:0]  rd;
      logic [8:0]  imm;
   } lc4_wform_t;

   typedef union packed {
      lc4_rform_t r;
      lc4_oform_t o;
      lc4_wform_t w;
   } lc4_insn_t;

endpackage

// ==== lc4_pipe_pkg.sv ====
package lc4_pipe_pkg;

   import lc4_isa_pkg::*;

   // decoded control, all zero is a bubble
   typedef struct packed {
      lc4_reg_t rs;
      logic     rs_re;
      lc4_reg_t rt;
      logic     rt_re;
      lc4_reg_t rd;
      logic     regfile_we;
      logic     nzp_we;
      logic     is_load;
      logic     is_store;
      logic     is_branch;
   } lc4_ctrl_t;

   typedef struct packed {
      lc4_word_t pc;
      lc4_insn_t insn;
      logic      valid;
   } lc4_fd_t;

   typedef struct packed {
      lc4_word_t pc;
      lc4_insn_t insn;
      lc4_ctrl_t ctrl;
      lc4_word_t rs_data;
      lc4_word_t rt_data;
   } lc4_dx_t;

   typedef struct packed {
      lc4_insn_t insn;
      lc4_ctrl_t ctrl;
      lc4_word_t alu_out;
      lc4_word_t store_data;
   } lc4_xm_t;

   // register and flag update of one instruction
   typedef struct packed {
      logic      we;
      lc4_reg_t  rd;
      lc4_word_t data;
      logic      nzp_we;
      lc4_nzp_t  nzp;
   } lc4_wb_t;

endpackage

// ==== lc4_fetch.sv ====
`include "lc4_defs.svh"

module lc4_fetch (
   input  logic                   gwe,
   input  logic                   i_rst_n,
   input  logic                   i_stall,
   input  logic                   i_redirect,
   input  lc4_isa_pkg::lc4_word_t i_target,
   input  lc4_isa_pkg::lc4_word_t i_imem_data,
   output lc4_isa_pkg::lc4_word_t o_imem_addr,
   output lc4_pipe_pkg::lc4_fd_t  o_fd
);

   import lc4_isa_pkg::*;

   lc4_word_t pc_q;
   lc4_word_t pc_next;

   // a taken branch wins over a load-use hold
   always_comb begin
      if (i_redirect) begin
         pc_next = i_target;
      end else if (i_stall) begin
         pc_next = pc_q;
      end else begin
         pc_next = pc_q + 1'b1;
      end
   end

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc_q <= `LC4_RESET_PC;
      end else begin
         pc_q <= pc_next;
      end
   end

   // fetch/decode register, the word fetched during a redirect is dropped
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_fd <= '0;
      end else if (i_redirect) begin
         o_fd <= '0;
      end else if (!i_stall) begin
         o_fd.pc    <= pc_q;
         o_fd.insn  <= i_imem_data;
         o_fd.valid <= 1'b1;
      end
   end

   assign o_imem_addr = pc_q;

endmodule

// ==== lc4_decoder.sv ====
module lc4_decoder (
   input  lc4_isa_pkg::lc4_insn_t  i_insn,
   output lc4_pipe_pkg::lc4_ctrl_t o_ctrl
);

   import lc4_isa_pkg::*;

   logic rr_op;
   logic ri_op;

   always_comb begin
      rr_op  = 1'b0;
      ri_op  = 1'b0;
      o_ctrl = '0;

      // ADD, SUB, ADD-immediate, AND, OR, XOR; MUL, DIV, NOT and AND-immediate fall out
      if (i_insn.r.opcode == op_arith) begin
         ri_op = i_insn.r.sub[2];
         rr_op = (i_insn.r.sub == 3'b000) || (i_insn.r.sub == 3'b010);
      end else if (i_insn.r.opcode == op_logic) begin
         rr_op = (i_insn.r.sub == 3'b000) || (i_insn.r.sub == 3'b010) ||
                 (i_insn.r.sub == 3'b011);
      end

      if (rr_op || ri_op) begin
         o_ctrl.rs         = i_insn.r.rs;
         o_ctrl.rs_re      = 1'b1;
         o_ctrl.rt         = i_insn.r.rt;
         o_ctrl.rt_re      = rr_op;
         o_ctrl.rd         = i_insn.r.rd;
         o_ctrl.regfile_we = 1'b1;
         o_ctrl.nzp_we     = 1'b1;
      end

      case (i_insn.r.opcode)
         op_br: begin
            o_ctrl.is_branch = 1'b1;
         end
         op_ldr: begin
            o_ctrl.rs         = i_insn.o.rs;
            o_ctrl.rs_re      = 1'b1;
            o_ctrl.rd         = i_insn.o.rd;
            o_ctrl.regfile_we = 1'b1;
            o_ctrl.nzp_we     = 1'b1;
            o_ctrl.is_load    = 1'b1;
         end
         op_str: begin
            // the data register sits where a load has rd
            o_ctrl.rs       = i_insn.o.rs;
            o_ctrl.rs_re    = 1'b1;
            o_ctrl.rt       = i_insn.o.rd;
            o_ctrl.rt_re    = 1'b1;
            o_ctrl.is_store = 1'b1;
         end
         op_const: begin
            o_ctrl.rd         = i_insn.w.rd;
            o_ctrl.regfile_we = 1'b1;
            o_ctrl.nzp_we     = 1'b1;
         end
         default: begin
         end
      endcase
   end

endmodule

// ==== lc4_regfile.sv ====
`include "lc4_defs.svh"

module lc4_regfile (
   input  logic                   gwe,
   input  logic                   i_rst_n,
   input  lc4_isa_pkg::lc4_reg_t  i_rs,
   input  lc4_isa_pkg::lc4_reg_t  i_rt,
   input  lc4_pipe_pkg::lc4_wb_t  i_wb,
   output lc4_isa_pkg::lc4_word_t o_rs_data,
   output lc4_isa_pkg::lc4_word_t o_rt_data
);

   import lc4_isa_pkg::*;

   lc4_word_t regs [`LC4_REG_CNT];

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < `LC4_REG_CNT; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wb.we) begin
         regs[i_wb.rd] <= i_wb.data;
      end
   end

   // writeback lands in the read of the same cycle
   assign o_rs_data = (i_wb.we && i_wb.rd == i_rs) ? i_wb.data : regs[i_rs];
   assign o_rt_data = (i_wb.we && i_wb.rd == i_rt) ? i_wb.data : regs[i_rt];

endmodule

// ==== lc4_decode.sv ====
module lc4_decode (
   input  logic                    gwe,
   input  logic                    i_rst_n,
   input  lc4_pipe_pkg::lc4_fd_t   i_fd,
   input  logic                    i_flush,
   input  lc4_pipe_pkg::lc4_ctrl_t i_x_ctrl,
   input  lc4_pipe_pkg::lc4_wb_t   i_wb,
   output logic                    o_stall,
   output lc4_pipe_pkg::lc4_dx_t   o_dx
);

   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;

   lc4_ctrl_t dec_ctrl;
   lc4_ctrl_t ctrl;
   lc4_word_t rs_data;
   lc4_word_t rt_data;
   logic      rs_hit;
   logic      rt_hit;

   lc4_decoder u_decoder (
      .i_insn (i_fd.insn),
      .o_ctrl (dec_ctrl)
   );

   // an empty fetch slot carries no control
   assign ctrl = i_fd.valid ? dec_ctrl : '0;

   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_rst_n   (i_rst_n),
      .i_rs      (ctrl.rs),
      .i_rt      (ctrl.rt),
      .i_wb      (i_wb),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data)
   );

   // store data of a load result is patched later, so only ALU and address operands wait
   assign rs_hit  = ctrl.rs_re && (ctrl.rs == i_x_ctrl.rd);
   assign rt_hit  = ctrl.rt_re && !ctrl.is_store && (ctrl.rt == i_x_ctrl.rd);
   assign o_stall = i_x_ctrl.is_load && i_x_ctrl.regfile_we && (rs_hit || rt_hit);

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_dx <= '0;
      end else begin
         o_dx.pc      <= i_fd.pc;
         o_dx.rs_data <= rs_data;
         o_dx.rt_data <= rt_data;
         if (o_stall || i_flush) begin
            o_dx.insn <= '0;
            o_dx.ctrl <= '0;
         end else begin
            o_dx.insn <= i_fd.insn;
            o_dx.ctrl <= ctrl;
         end
      end
   end

   // the bubble sent behind a load can never itself be a load
   a_stall_single : assert property (@(posedge gwe) disable iff (!i_rst_n)
      o_stall |=> !o_stall);

endmodule

// ==== lc4_alu.sv ====
module lc4_alu (
   input  lc4_isa_pkg::lc4_insn_t i_insn,
   input  lc4_isa_pkg::lc4_word_t i_pc,
   input  lc4_isa_pkg::lc4_word_t i_a,
   input  lc4_isa_pkg::lc4_word_t i_b,
   output lc4_isa_pkg::lc4_word_t o_result
);

   import lc4_isa_pkg::*;

   lc4_word_t imm5;
   lc4_word_t imm6;
   lc4_word_t imm9;

   // sign extended immediates of the three formats
   assign imm5 = {{11{i_insn.o.imm[4]}}, i_insn.o.imm[4:0]};
   assign imm6 = {{10{i_insn.o.imm[5]}}, i_insn.o.imm};
   assign imm9 = {{7{i_insn.w.imm[8]}}, i_insn.w.imm};

   always_comb begin
      case (i_insn.r.opcode)
         op_arith: begin
            if (i_insn.r.sub[2]) begin
               o_result = i_a + imm5;
            end else if (i_insn.r.sub == 3'b010) begin
               o_result = i_a - i_b;
            end else begin
               o_result = i_a + i_b;
            end
         end
         op_logic: begin
            case (i_insn.r.sub)
               3'b010:  o_result = i_a | i_b;
               3'b011:  o_result = i_a ^ i_b;
               default: o_result = i_a & i_b;
            endcase
         end
         op_ldr, op_str: o_result = i_a + imm6;
         op_const:       o_result = imm9;
         // branch target, relative to the next sequential PC
         op_br:          o_result = i_pc + 1'b1 + imm9;
         default:        o_result = '0;
      endcase
   end

endmodule

// ==== lc4_execute.sv ====
module lc4_execute (
   input  logic                   gwe,
   input  logic                   i_rst_n,
   input  lc4_pipe_pkg::lc4_dx_t  i_dx,
   input  lc4_pipe_pkg::lc4_wb_t  i_m_wb,
   input  lc4_pipe_pkg::lc4_wb_t  i_w_wb,
   input  lc4_isa_pkg::lc4_nzp_t  i_nzp,
   output logic                   o_redirect,
   output lc4_isa_pkg::lc4_word_t o_target,
   output lc4_pipe_pkg::lc4_xm_t  o_xm
);

   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;

   lc4_word_t op_a;
   lc4_word_t op_b;
   lc4_word_t alu_out;
   lc4_nzp_t  nzp;

   // youngest older writer wins, the decode read is the fallback
   function automatic lc4_word_t fwd(
      input lc4_reg_t  r,
      input lc4_word_t rf_data,
      input lc4_wb_t   m_wb,
      input lc4_wb_t   w_wb
   );
      if (m_wb.we && m_wb.rd == r) begin
         return m_wb.data;
      end
      if (w_wb.we && w_wb.rd == r) begin
         return w_wb.data;
      end
      return rf_data;
   endfunction

   assign op_a = fwd(i_dx.ctrl.rs, i_dx.rs_data, i_m_wb, i_w_wb);
   assign op_b = fwd(i_dx.ctrl.rt, i_dx.rt_data, i_m_wb, i_w_wb);

   lc4_alu u_alu (
      .i_insn   (i_dx.insn),
      .i_pc     (i_dx.pc),
      .i_a      (op_a),
      .i_b      (op_b),
      .o_result (alu_out)
   );

   // flags of a load right ahead come from the memory stage
   always_comb begin
      if (i_m_wb.nzp_we) begin
         nzp = i_m_wb.nzp;
      end else if (i_w_wb.nzp_we) begin
         nzp = i_w_wb.nzp;
      end else begin
         nzp = i_nzp;
      end
   end

   // mask 000 is a nop and never redirects
   assign o_redirect = i_dx.ctrl.is_branch && (|(i_dx.insn.w.rd & nzp));
   assign o_target   = alu_out;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_xm <= '0;
      end else begin
         o_xm.insn       <= i_dx.insn;
         o_xm.ctrl       <= i_dx.ctrl;
         o_xm.alu_out    <= alu_out;
         o_xm.store_data <= op_b;
      end
   end

   // decode flushes behind a taken branch, so a second branch cannot follow directly
   a_redirect_single : assert property (@(posedge gwe) disable iff (!i_rst_n)
      o_redirect |=> !o_redirect);

endmodule

// ==== lc4_memory.sv ====
module lc4_memory (
   input  logic                   gwe,
   input  logic                   i_rst_n,
   input  lc4_pipe_pkg::lc4_xm_t  i_xm,
   input  lc4_isa_pkg::lc4_word_t i_dmem_rdata,
   output lc4_isa_pkg::lc4_word_t o_dmem_addr,
   output lc4_isa_pkg::lc4_word_t o_dmem_wdata,
   output logic                   o_dmem_we,
   output lc4_pipe_pkg::lc4_wb_t  o_m_wb,
   output lc4_pipe_pkg::lc4_wb_t  o_w_wb,
   output lc4_isa_pkg::lc4_nzp_t  o_nzp
);

   import lc4_isa_pkg::*;

   lc4_word_t result;
   logic      mem_op;

   assign mem_op      = i_xm.ctrl.is_load || i_xm.ctrl.is_store;
   assign o_dmem_addr = mem_op ? i_xm.alu_out : '0;
   assign o_dmem_we   = i_xm.ctrl.is_store;

   // writer now in writeback overrides the store data
   assign o_dmem_wdata = (o_w_wb.we && o_w_wb.rd == i_xm.ctrl.rt) ? o_w_wb.data
                                                                 : i_xm.store_data;

   assign result = i_xm.ctrl.is_load ? i_dmem_rdata : i_xm.alu_out;

   // candidate bus, forwarded to execute before it is registered
   always_comb begin
      o_m_wb.we     = i_xm.ctrl.regfile_we;
      o_m_wb.rd     = i_xm.ctrl.rd;
      o_m_wb.data   = result;
      o_m_wb.nzp_we = i_xm.ctrl.nzp_we;
      o_m_wb.nzp.n  = result[15];
      o_m_wb.nzp.z  = (result == '0);
      o_m_wb.nzp.p  = !result[15] && (result != '0);
   end

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_w_wb <= '0;
      end else begin
         o_w_wb <= o_m_wb;
      end
   end

   // flags commit with the register write; registers start at zero, so Z
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_nzp <= 3'b010;
      end else if (o_w_wb.nzp_we) begin
         o_nzp <= o_w_wb.nzp;
      end
   end

   // raw opcode against the decoded control carried down the pipe
   a_no_store_on_load : assert property (@(posedge gwe) disable iff (!i_rst_n)
      !(o_dmem_we && i_xm.insn.r.opcode == op_ldr));

endmodule

// ==== lc4_pipeline.sv ====
module lc4_pipeline (
   input  logic                   gwe,
   input  logic                   i_rst_n,
   input  lc4_isa_pkg::lc4_word_t i_imem_data,
   input  lc4_isa_pkg::lc4_word_t i_dmem_rdata,
   output lc4_isa_pkg::lc4_word_t o_imem_addr,
   output lc4_isa_pkg::lc4_word_t o_dmem_addr,
   output lc4_isa_pkg::lc4_word_t o_dmem_wdata,
   output logic                   o_dmem_we
);

   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;

   lc4_fd_t   fd;
   lc4_dx_t   dx;
   lc4_xm_t   xm;
   lc4_wb_t   m_wb;
   lc4_wb_t   w_wb;
   lc4_nzp_t  nzp;
   lc4_word_t target;
   logic      stall;
   logic      redirect;

   lc4_fetch u_fetch (
      .gwe         (gwe),
      .i_rst_n     (i_rst_n),
      .i_stall     (stall),
      .i_redirect  (redirect),
      .i_target    (target),
      .i_imem_data (i_imem_data),
      .o_imem_addr (o_imem_addr),
      .o_fd        (fd)
   );

   lc4_decode u_decode (
      .gwe      (gwe),
      .i_rst_n  (i_rst_n),
      .i_fd     (fd),
      .i_flush  (redirect),
      .i_x_ctrl (dx.ctrl),
      .i_wb     (w_wb),
      .o_stall  (stall),
      .o_dx     (dx)
   );

   lc4_execute u_execute (
      .gwe        (gwe),
      .i_rst_n    (i_rst_n),
      .i_dx       (dx),
      .i_m_wb     (m_wb),
      .i_w_wb     (w_wb),
      .i_nzp      (nzp),
      .o_redirect (redirect),
      .o_target   (target),
      .o_xm       (xm)
   );

   lc4_memory u_memory (
      .gwe          (gwe),
      .i_rst_n      (i_rst_n),
      .i_xm         (xm),
      .i_dmem_rdata (i_dmem_rdata),
      .o_dmem_addr  (o_dmem_addr),
      .o_dmem_wdata (o_dmem_wdata),
      .o_dmem_we    (o_dmem_we),
      .o_m_wb       (m_wb),
      .o_w_wb       (w_wb),
      .o_nzp        (nzp)
   );

endmodule

// ==== tb_lc4_pipeline.sv ====
`include "lc4_defs.svh"

module tb_lc4_pipeline;

   import lc4_isa_pkg::*;

   parameter integer SEED = 32'heeca;

   logic      gwe;
   logic      rst_n;
   lc4_word_t imem_data;
   lc4_word_t dmem_rdata;
   lc4_word_t imem_addr;
   lc4_word_t dmem_addr;
   lc4_word_t dmem_wdata;
   logic      dmem_we;

   lc4_word_t imem [65536];
   lc4_word_t dmem [65536];
   lc4_word_t ref_dmem [65536];
   lc4_word_t prog [$];
   lc4_word_t exp_addr_q [$];
   lc4_word_t exp_data_q [$];
   integer    seed;

   lc4_pipeline u_lc4_pipeline (
      .gwe          (gwe),
      .i_rst_n      (rst_n),
      .i_imem_data  (imem_data),
      .i_dmem_rdata (dmem_rdata),
      .o_imem_addr  (imem_addr),
      .o_dmem_addr  (dmem_addr),
      .o_dmem_wdata (dmem_wdata),
      .o_dmem_we    (dmem_we)
   );

   // both memories answer in the same cycle
   assign imem_data  = imem[imem_addr];
   assign dmem_rdata = dmem[dmem_addr];

   initial begin
      gwe = 1'b0;
      forever #4 gwe = ~gwe;
   end

   always @(posedge gwe) begin
      if (rst_n && dmem_we) begin
         dmem[dmem_addr] <= dmem_wdata;
      end
   end

   task automatic value_fail(input string msg);
      $display("Test FAILED");
      $display("FAILED at time %0t: %s", $time, msg);
      $fatal(1, "wrong value");
   endtask

   task automatic timeout_fail(input string msg);
      $display("Test FAILED");
      $display("gave up waiting: %s", msg);
      $fatal(1, "timeout");
   endtask

   task automatic check_store(input lc4_word_t exp_addr, input lc4_word_t exp_data,
                              input lc4_word_t got_addr, input lc4_word_t got_data);
      if (got_addr !== exp_addr || got_data !== exp_data) begin
         value_fail($sformatf("store expected [%h] <= %h, got [%h] <= %h",
                              exp_addr, exp_data, got_addr, got_data));
      end
   endtask

   task automatic check_pc(input lc4_word_t exp_pc, input lc4_word_t got_pc);
      if (got_pc !== exp_pc) begin
         value_fail($sformatf("fetch address expected %h, got %h", exp_pc, got_pc));
      end
   endtask

   // every store of the DUT is matched in order against the reference stream
   always @(posedge gwe) begin
      if (rst_n && dmem_we) begin
         if (exp_addr_q.size() == 0) begin
            value_fail($sformatf("unexpected store [%h] <= %h", dmem_addr, dmem_wdata));
         end else begin
            check_store(exp_addr_q.pop_front(), exp_data_q.pop_front(), dmem_addr,
                        dmem_wdata);
         end
      end
   end

   function automatic int pick(input int n);
      return {$random(seed)} % n;
   endfunction

   function automatic lc4_word_t reg_op(input logic [3:0] op, input logic [2:0] rd,
                                        input logic [2:0] rs, input logic [2:0] sub,
                                        input logic [2:0] rt);
      return {op, rd, rs, sub, rt};
   endfunction

   function automatic lc4_word_t addi_op(input logic [2:0] rd, input logic [2:0] rs,
                                         input logic [4:0] imm);
      return {4'b0001, rd, rs, 1'b1, imm};
   endfunction

   function automatic lc4_word_t mem_op(input logic [3:0] op, input logic [2:0] r,
                                        input logic [2:0] base, input logic [5:0] imm);
      return {op, r, base, imm};
   endfunction

   function automatic lc4_word_t wide_op(input logic [3:0] op, input logic [2:0] rd,
                                         input logic [8:0] imm);
      return {op, rd, imm};
   endfunction

   function automatic logic [2:0] flags_of(input lc4_word_t v);
      if (v[15]) begin
         return 3'b100;
      end
      return (v == '0) ? 3'b010 : 3'b001;
   endfunction

   // instruction by instruction interpreter, fills the expected store stream
   function automatic logic reference(output lc4_word_t halt_pc);
      lc4_word_t  r [8];
      lc4_word_t  pc;
      lc4_word_t  next_pc;
      lc4_word_t  insn;
      lc4_word_t  res;
      lc4_word_t  addr;
      logic [2:0] nzp;
      logic       wr;
      for (int i = 0; i < 8; i++) begin
         r[i] = '0;
      end
      pc = `LC4_RESET_PC;
      nzp = 3'b010;
      halt_pc = '0;
      for (int step = 0; step < `LC4_HALT_CYCLES; step++) begin
         insn = imem[pc];
         next_pc = pc + 16'd1;
         wr = 1'b0;
         res = '0;
         case (insn[15:12])
            4'b0000: begin
               addr = pc + 16'd1 + {{7{insn[8]}}, insn[8:0]};
               if ((insn[11:9] & nzp) != 3'b000) begin
                  // a taken branch onto itself is the halt loop
                  if (addr == pc) begin
                     halt_pc = pc;
                     return 1'b1;
                  end
                  next_pc = addr;
               end
            end
            4'b0001: begin
               wr = 1'b1;
               if (insn[5]) begin
                  res = r[insn[8:6]] + {{11{insn[4]}}, insn[4:0]};
               end else if (insn[5:3] == 3'b010) begin
                  res = r[insn[8:6]] - r[insn[2:0]];
               end else begin
                  res = r[insn[8:6]] + r[insn[2:0]];
               end
            end
            4'b0101: begin
               wr = 1'b1;
               case (insn[5:3])
                  3'b010:  res = r[insn[8:6]] | r[insn[2:0]];
                  3'b011:  res = r[insn[8:6]] ^ r[insn[2:0]];
                  default: res = r[insn[8:6]] & r[insn[2:0]];
               endcase
            end
            4'b0110: begin
               wr = 1'b1;
               res = ref_dmem[r[insn[8:6]] + {{10{insn[5]}}, insn[5:0]}];
            end
            4'b0111: begin
               addr = r[insn[8:6]] + {{10{insn[5]}}, insn[5:0]};
               ref_dmem[addr] = r[insn[11:9]];
               exp_addr_q.push_back(addr);
               exp_data_q.push_back(r[insn[11:9]]);
            end
            4'b1001: begin
               wr = 1'b1;
               res = {{7{insn[8]}}, insn[8:0]};
            end
            default: begin
            end
         endcase
         if (wr) begin
            r[insn[11:9]] = res;
            nzp = flags_of(res);
         end
         pc = next_pc;
      end
      return 1'b0;
   endfunction

   // dump of all registers relative to r7, then the halt loop
   task automatic close_program();
      for (int i = 0; i < 8; i++) begin
         prog.push_back(mem_op(op_str, 3'(i), 3'd7, 6'(i)));
      end
      prog.push_back(wide_op(op_br, 3'b111, 9'h1ff));
   endtask

   task automatic build_alu_chain();
      prog.delete();
      prog.push_back(wide_op(op_const, 3'd1, 9'd5));
      prog.push_back(wide_op(op_const, 3'd2, 9'h1fd));
      prog.push_back(reg_op(op_arith, 3'd3, 3'd1, 3'b000, 3'd2));
      prog.push_back(reg_op(op_arith, 3'd4, 3'd3, 3'b010, 3'd1));
      prog.push_back(addi_op(3'd5, 3'd4, 5'd7));
      prog.push_back(reg_op(op_logic, 3'd6, 3'd5, 3'b000, 3'd3));
      prog.push_back(reg_op(op_logic, 3'd1, 3'd6, 3'b010, 3'd4));
      prog.push_back(reg_op(op_logic, 3'd2, 3'd1, 3'b011, 3'd5));
      prog.push_back(reg_op(op_arith, 3'd3, 3'd2, 3'b000, 3'd2));
      prog.push_back(addi_op(3'd3, 3'd3, 5'h10));
      prog.push_back(wide_op(op_const, 3'd7, 9'h050));
      prog.push_back(mem_op(op_str, 3'd3, 3'd7, 6'd0));
      prog.push_back(reg_op(op_arith, 3'd0, 3'd3, 3'b010, 3'd2));
      prog.push_back(reg_op(op_logic, 3'd0, 3'd0, 3'b011, 3'd3));
      prog.push_back(mem_op(op_str, 3'd0, 3'd7, 6'd1));
      close_program();
   endtask

   task automatic build_load_use();
      prog.delete();
      prog.push_back(wide_op(op_const, 3'd7, 9'h040));
      prog.push_back(mem_op(op_ldr, 3'd1, 3'd7, 6'd3));
      prog.push_back(reg_op(op_arith, 3'd2, 3'd1, 3'b000, 3'd1));
      prog.push_back(mem_op(op_ldr, 3'd3, 3'd7, 6'd5));
      prog.push_back(mem_op(op_str, 3'd3, 3'd7, 6'd10));
      prog.push_back(mem_op(op_ldr, 3'd4, 3'd7, 6'h3e));
      // loaded value used at once as a base address
      prog.push_back(mem_op(op_ldr, 3'd5, 3'd4, 6'd0));
      prog.push_back(mem_op(op_str, 3'd5, 3'd7, 6'd11));
      prog.push_back(mem_op(op_ldr, 3'd6, 3'd7, 6'd1));
      prog.push_back(reg_op(op_logic, 3'd6, 3'd6, 3'b011, 3'd1));
      prog.push_back(mem_op(op_ldr, 3'd0, 3'd7, 6'd2));
      prog.push_back(addi_op(3'd0, 3'd0, 5'd1));
      close_program();
   endtask

   task automatic build_branches();
      logic [8:0] vals [3];
      vals[0] = 9'h1fb;
      vals[1] = 9'h000;
      vals[2] = 9'h009;
      prog.delete();
      prog.push_back(wide_op(op_const, 3'd6, 9'h030));
      for (int k = 0; k < 3; k++) begin
         prog.push_back(wide_op(op_const, 3'd5, vals[k]));
         prog.push_back(mem_op(op_str, 3'd5, 3'd6, 6'(k)));
      end
      prog.push_back(wide_op(op_const, 3'd7, 9'h060));
      prog.push_back(wide_op(op_const, 3'd1, 9'h011));
      prog.push_back(wide_op(op_const, 3'd2, 9'h022));
      for (int m = 0; m < 8; m++) begin
         for (int k = 0; k < 3; k++) begin
            // flags from an ALU op or from a load right ahead of the branch
            if ((m + k) % 2 == 0) begin
               prog.push_back(wide_op(op_const, 3'd3, vals[k]));
               prog.push_back(addi_op(3'd4, 3'd3, 5'd0));
            end else begin
               prog.push_back(mem_op(op_ldr, 3'd4, 3'd6, 6'(k)));
            end
            prog.push_back(wide_op(op_br, 3'(m), 9'd2));
            prog.push_back(mem_op(op_str, 3'd1, 3'd7, 6'(m * 3 + k)));
            prog.push_back(mem_op(op_str, 3'd2, 3'd7, 6'(m * 3 + k) | 6'h20));
         end
      end
      close_program();
   endtask

   task automatic build_random();
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] rt;
      prog.delete();
      for (int r = 0; r < 8; r++) begin
         prog.push_back(wide_op(op_const, 3'(r), 9'(pick(512))));
      end
      for (int i = 0; i < 24; i++) begin
         rd = 3'(pick(8));
         rs = 3'(pick(8));
         rt = 3'(pick(8));
         case (pick(10))
            0: prog.push_back(reg_op(op_arith, rd, rs, 3'b000, rt));
            1: prog.push_back(reg_op(op_arith, rd, rs, 3'b010, rt));
            2: prog.push_back(addi_op(rd, rs, 5'(pick(32))));
            3: prog.push_back(reg_op(op_logic, rd, rs, 3'b000, rt));
            4: prog.push_back(reg_op(op_logic, rd, rs, 3'b010, rt));
            5: prog.push_back(reg_op(op_logic, rd, rs, 3'b011, rt));
            6: prog.push_back(wide_op(op_const, rd, 9'(pick(512))));
            7: prog.push_back(mem_op(op_ldr, rd, rs, 6'(pick(64))));
            8: prog.push_back(mem_op(op_str, rd, rs, 6'(pick(64))));
            // forward only, at least eight words remain before the halt loop
            default: prog.push_back(wide_op(op_br, 3'(pick(8)), 9'(pick(4))));
         endcase
      end
      close_program();
   endtask

   task automatic run_program(input string name, input lc4_word_t salt);
      lc4_word_t halt_pc;
      logic      ended;
      int        cyc;
      @(negedge gwe);
      rst_n = 1'b0;
      for (int a = 0; a < 65536; a++) begin
         // unused code words are nzp 000 branches, i.e. nops
         imem[a] = {7'b0, a[8:0] ^ {2'b00, a[15:9]}};
         dmem[a] = {a[7:0], a[15:8]} ^ 16'h3c5a ^ salt;
         ref_dmem[a] = dmem[a];
      end
      foreach (prog[i]) begin
         imem[16'(`LC4_RESET_PC + i)] = prog[i];
      end
      exp_addr_q.delete();
      exp_data_q.delete();
      ended = reference(halt_pc);
      if (!ended) begin
         timeout_fail({name, ": reference interpreter never reached the halt loop"});
      end
      repeat (2) @(negedge gwe);
      check_pc(`LC4_RESET_PC, imem_addr);
      if (dmem_we !== 1'b0) begin
         value_fail({name, ": data memory write enable set during reset"});
      end
      rst_n = 1'b1;
      cyc = 0;
      while (imem_addr !== halt_pc && cyc < `LC4_HALT_CYCLES) begin
         @(negedge gwe);
         cyc++;
      end
      if (cyc >= `LC4_HALT_CYCLES) begin
         timeout_fail({name, ": fetch never reached the halt address"});
      end
      // the halt branch resolves in execute and sends fetch back onto itself
      repeat (3) @(negedge gwe);
      check_pc(halt_pc, imem_addr);
      cyc = 0;
      while (exp_addr_q.size() != 0 && cyc < `LC4_HALT_CYCLES) begin
         @(negedge gwe);
         cyc++;
      end
      if (cyc >= `LC4_HALT_CYCLES) begin
         timeout_fail({name, ": expected stores never appeared"});
      end
      // stay in the halt loop a while, any late store is flagged
      repeat (12) @(negedge gwe);
   endtask

   initial begin
      rst_n = 1'b0;
      seed = SEED;
      build_alu_chain();
      run_program("alu chain", 16'h0000);
      build_load_use();
      run_program("load use", 16'h1111);
      build_branches();
      run_program("branches", 16'h2222);
      for (int p = 0; p < 20; p++) begin
         build_random();
         run_program($sformatf("random program %0d", p), 16'(p * 16'h0b3d));
      end
      $display("Test OK");
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+.
lc4_isa_pkg.sv
lc4_pipe_pkg.sv
lc4_fetch.sv
lc4_decoder.sv
lc4_regfile.sv
lc4_decode.sv
lc4_alu.sv
lc4_execute.sv
lc4_memory.sv
lc4_pipeline.sv
tb_lc4_pipeline.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lc4_pipeline
LINT_TOP  ?= lc4_pipeline
SEED      ?= 61130
FLAGS     ?=
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert -Wno-fatal --top-module $(LINT_TOP) \
		-f $(FLIST) $(FLAGS)

sim:
	$(VERILATOR) --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-GSEED=$(SEED) -f $(FLIST) --Mdir $(OBJ_DIR) $(FLAGS)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
